// File: design/rv_slice_macros.svh
`ifndef RV_SLICE_MACROS_SVH
`define RV_SLICE_MACROS_SVH

// integer data path width
`define XLEN 64

// destination register index
`define REG_ADDR_WIDTH 5

// 64-bit words in the data memory, byte address wraps at 8x this
`define DMEM_WORDS 64

`endif

// File: design/rv_slice_pkg.sv
package rv_slice_pkg;

	// alu function select
	typedef enum logic [3:0] {
		ALU_ADD  = 4'h0,
		ALU_SUB  = 4'h1,
		ALU_AND  = 4'h2,
		ALU_OR   = 4'h3,
		ALU_XOR  = 4'h4,
		ALU_SLL  = 4'h5,
		ALU_SRL  = 4'h6,
		ALU_SRA  = 4'h7,
		ALU_SLT  = 4'h8,
		ALU_SLTU = 4'h9
	} alu_op_e;

	// loads in 1..7, stores in 8..11
	typedef enum logic [3:0] {
		MEM_NONE = 4'h0,
		MEM_LB   = 4'h1,
		MEM_LH   = 4'h2,
		MEM_LW   = 4'h3,
		MEM_LD   = 4'h4,
		MEM_LBU  = 4'h5,
		MEM_LHU  = 4'h6,
		MEM_LWU  = 4'h7,
		MEM_SB   = 4'h8,
		MEM_SH   = 4'h9,
		MEM_SW   = 4'hA,
		MEM_SD   = 4'hB
	} mem_op_e;

endpackage

// File: design/ex_stage.sv
`timescale 1ns/1ps
`include "rv_slice_macros.svh"

module ex_stage (
	input  rv_slice_pkg::alu_op_e alu_op_i,
	input  rv_slice_pkg::mem_op_e mem_op_i,
	input  logic [`XLEN-1:0]      src1_i,
	input  logic [`XLEN-1:0]      src2_i,
	input  logic [31:0]           imm_i,
	input  logic                  reg_wen_i,
	output logic [`XLEN-1:0]      alu_res_o,    // alu result or effective address
	output logic [`XLEN-1:0]      store_data_o, // store data moved to its byte lane
	output logic [7:0]            wmask_o,
	output logic [3:0]            load_ext_o,   // {signed, byte, half, word}
	output rv_slice_pkg::mem_op_e mem_op_o,
	output logic                  reg_wen_o
);

	logic [`XLEN-1:0] imm_sext;
	logic [`XLEN-1:0] eff_addr;
	logic [5:0]       shamt;
	logic [2:0]       lane;
	logic             is_store;

	assign imm_sext = {{(`XLEN-32){imm_i[31]}}, imm_i};
	assign eff_addr = src1_i + imm_sext;
	assign shamt    = src2_i[5:0]; // rv64 shifts use 6 bits
	assign lane     = eff_addr[2:0];

	assign is_store = (mem_op_i == rv_slice_pkg::MEM_SB) ||
		(mem_op_i == rv_slice_pkg::MEM_SH) ||
		(mem_op_i == rv_slice_pkg::MEM_SW) ||
		(mem_op_i == rv_slice_pkg::MEM_SD);

	// alu, any memory op turns it into the address adder
	always_comb begin
		if (mem_op_i != rv_slice_pkg::MEM_NONE) begin
			alu_res_o = eff_addr;
		end else begin
			case (alu_op_i)
				rv_slice_pkg::ALU_ADD:  alu_res_o = src1_i + src2_i;
				rv_slice_pkg::ALU_SUB:  alu_res_o = src1_i - src2_i;
				rv_slice_pkg::ALU_AND:  alu_res_o = src1_i & src2_i;
				rv_slice_pkg::ALU_OR:   alu_res_o = src1_i | src2_i;
				rv_slice_pkg::ALU_XOR:  alu_res_o = src1_i ^ src2_i;
				rv_slice_pkg::ALU_SLL:  alu_res_o = src1_i << shamt;
				rv_slice_pkg::ALU_SRL:  alu_res_o = src1_i >> shamt;
				rv_slice_pkg::ALU_SRA:  alu_res_o = $signed(src1_i) >>> shamt;
				rv_slice_pkg::ALU_SLT:
					alu_res_o = {{(`XLEN-1){1'b0}}, $signed(src1_i) < $signed(src2_i)};
				rv_slice_pkg::ALU_SLTU:
					alu_res_o = {{(`XLEN-1){1'b0}}, src1_i < src2_i};
				default:                alu_res_o = '0;
			endcase
		end
	end

	// byte lane of the low store bytes follows address bits 2:0
	assign store_data_o = src2_i << {lane, 3'b000};

	always_comb begin
		wmask_o = 8'h00;
		case (mem_op_i)
			rv_slice_pkg::MEM_SB: wmask_o = 8'h01 << lane;
			rv_slice_pkg::MEM_SH: wmask_o = 8'h03 << lane;
			rv_slice_pkg::MEM_SW: wmask_o = 8'h0f << lane;
			rv_slice_pkg::MEM_SD: wmask_o = 8'hff << lane; // misaligned bytes drop off the top
			default:              wmask_o = 8'h00;
		endcase
	end

	// size and sign of a load, zero low bits mean a full doubleword
	always_comb begin
		case (mem_op_i)
			rv_slice_pkg::MEM_LB:  load_ext_o = 4'b1100;
			rv_slice_pkg::MEM_LH:  load_ext_o = 4'b1010;
			rv_slice_pkg::MEM_LW:  load_ext_o = 4'b1001;
			rv_slice_pkg::MEM_LD:  load_ext_o = 4'b1000;
			rv_slice_pkg::MEM_LBU: load_ext_o = 4'b0100;
			rv_slice_pkg::MEM_LHU: load_ext_o = 4'b0010;
			rv_slice_pkg::MEM_LWU: load_ext_o = 4'b0001;
			default:               load_ext_o = 4'b0000;
		endcase
	end

	assign mem_op_o  = mem_op_i;
	assign reg_wen_o = reg_wen_i & ~is_store; // stores never write rd

endmodule

// File: design/ex_mem_regs.sv
`timescale 1ns/1ps
`include "rv_slice_macros.svh"

module ex_mem_regs (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       flush_i,
	input  logic [`XLEN-1:0]           alu_res_i,
	input  logic [`XLEN-1:0]           store_data_i,
	input  logic [7:0]                 wmask_i,
	input  logic [3:0]                 load_ext_i,
	input  rv_slice_pkg::mem_op_e      mem_op_i,
	input  logic                       reg_wen_i,
	input  logic [`REG_ADDR_WIDTH-1:0] reg_waddr_i,
	output logic [`XLEN-1:0]           alu_res_o,
	output logic [`XLEN-1:0]           store_data_o,
	output logic [7:0]                 wmask_o,
	output logic [3:0]                 load_ext_o,
	output rv_slice_pkg::mem_op_e      mem_op_o,
	output logic                       reg_wen_o,
	output logic [`REG_ADDR_WIDTH-1:0] reg_waddr_o
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			alu_res_o    <= '0;
			store_data_o <= '0;
			wmask_o      <= 8'h00;
			load_ext_o   <= 4'h0;
			mem_op_o     <= rv_slice_pkg::MEM_NONE;
			reg_wen_o    <= 1'b0;
			reg_waddr_o  <= '0;
		end else begin
			// data fields pass through even under flush
			alu_res_o    <= alu_res_i;
			store_data_o <= store_data_i;
			load_ext_o   <= load_ext_i;
			reg_waddr_o  <= reg_waddr_i;
			if (flush_i) begin
				// cancel anything with a side effect
				wmask_o   <= 8'h00;
				mem_op_o  <= rv_slice_pkg::MEM_NONE;
				reg_wen_o <= 1'b0;
			end else begin
				wmask_o   <= wmask_i;
				mem_op_o  <= mem_op_i;
				reg_wen_o <= reg_wen_i;
			end
		end
	end

endmodule

// File: design/mem_stage.sv
`timescale 1ns/1ps
`include "rv_slice_macros.svh"

module mem_stage (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [`XLEN-1:0]           alu_res_i,    // alu result or byte address
	input  logic [`XLEN-1:0]           store_data_i,
	input  logic [7:0]                 wmask_i,
	input  logic [3:0]                 load_ext_i,
	input  rv_slice_pkg::mem_op_e      mem_op_i,
	input  logic                       reg_wen_i,
	input  logic [`REG_ADDR_WIDTH-1:0] reg_waddr_i,
	output logic                       wb_wen_o,
	output logic [`REG_ADDR_WIDTH-1:0] wb_waddr_o,
	output logic [`XLEN-1:0]           wb_data_o
);

	localparam int IDX_W = $clog2(`DMEM_WORDS);

	logic [`XLEN-1:0] dmem [`DMEM_WORDS];

	logic [IDX_W-1:0] idx;
	logic [2:0]       lane;
	logic             is_store;
	logic             is_load;
	logic [`XLEN-1:0] rd_word;
	logic [`XLEN-1:0] rd_shift;
	logic [`XLEN-1:0] load_val;

	assign idx  = alu_res_i[IDX_W+2:3]; // word index, upper address bits wrap
	assign lane = alu_res_i[2:0];

	assign is_store = (mem_op_i == rv_slice_pkg::MEM_SB) ||
		(mem_op_i == rv_slice_pkg::MEM_SH) ||
		(mem_op_i == rv_slice_pkg::MEM_SW) ||
		(mem_op_i == rv_slice_pkg::MEM_SD);
	assign is_load  = (mem_op_i != rv_slice_pkg::MEM_NONE) && !is_store;

	// byte-masked write at the edge that ends the mem cycle
	always_ff @(posedge clk) begin
		if (is_store) begin
			for (int b = 0; b < 8; b++) begin
				if (wmask_i[b])
					dmem[idx][b*8 +: 8] <= store_data_i[b*8 +: 8];
			end
		end
	end

	// async read, a load right behind a store sees the new bytes
	assign rd_word  = dmem[idx];
	assign rd_shift = rd_word >> {lane, 3'b000};

	always_comb begin
		if (load_ext_i[2]) begin
			load_val = load_ext_i[3] ? {{(`XLEN-8){rd_shift[7]}}, rd_shift[7:0]}
				: {{(`XLEN-8){1'b0}}, rd_shift[7:0]};
		end else if (load_ext_i[1]) begin
			load_val = load_ext_i[3] ? {{(`XLEN-16){rd_shift[15]}}, rd_shift[15:0]}
				: {{(`XLEN-16){1'b0}}, rd_shift[15:0]};
		end else if (load_ext_i[0]) begin
			load_val = load_ext_i[3] ? {{(`XLEN-32){rd_shift[31]}}, rd_shift[31:0]}
				: {{(`XLEN-32){1'b0}}, rd_shift[31:0]};
		end else begin
			load_val = rd_shift; // doubleword
		end
	end

	// writeback register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_wen_o   <= 1'b0;
			wb_waddr_o <= '0;
			wb_data_o  <= '0;
		end else begin
			wb_wen_o   <= reg_wen_i;
			wb_waddr_o <= reg_waddr_i;
			wb_data_o  <= is_load ? load_val : alu_res_i;
		end
	end

endmodule

// File: design/rv_slice_top.sv
`timescale 1ns/1ps
`include "rv_slice_macros.svh"

module rv_slice_top (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       flush_i,
	input  rv_slice_pkg::alu_op_e      alu_op_i,
	input  rv_slice_pkg::mem_op_e      mem_op_i,
	input  logic [`XLEN-1:0]           src1_i,
	input  logic [`XLEN-1:0]           src2_i,
	input  logic [31:0]                imm_i,
	input  logic [`REG_ADDR_WIDTH-1:0] reg_waddr_i,
	input  logic                       reg_wen_i,
	output logic                       wb_wen_o,
	output logic [`REG_ADDR_WIDTH-1:0] wb_waddr_o,
	output logic [`XLEN-1:0]           wb_data_o
);

	// execute stage outputs
	logic [`XLEN-1:0]           ex_alu_res;
	logic [`XLEN-1:0]           ex_store_data;
	logic [7:0]                 ex_wmask;
	logic [3:0]                 ex_load_ext;
	rv_slice_pkg::mem_op_e      ex_mem_op;
	logic                       ex_reg_wen;

	// pipeline register outputs
	logic [`XLEN-1:0]           mem_alu_res;
	logic [`XLEN-1:0]           mem_store_data;
	logic [7:0]                 mem_wmask;
	logic [3:0]                 mem_load_ext;
	rv_slice_pkg::mem_op_e      mem_mem_op;
	logic                       mem_reg_wen;
	logic [`REG_ADDR_WIDTH-1:0] mem_reg_waddr;

	ex_stage u_ex_stage (
		.alu_op_i     (alu_op_i),
		.mem_op_i     (mem_op_i),
		.src1_i       (src1_i),
		.src2_i       (src2_i),
		.imm_i        (imm_i),
		.reg_wen_i    (reg_wen_i),
		.alu_res_o    (ex_alu_res),
		.store_data_o (ex_store_data),
		.wmask_o      (ex_wmask),
		.load_ext_o   (ex_load_ext),
		.mem_op_o     (ex_mem_op),
		.reg_wen_o    (ex_reg_wen)
	);

	ex_mem_regs u_ex_mem_regs (
		.clk          (clk),
		.rst_n        (rst_n),
		.flush_i      (flush_i),
		.alu_res_i    (ex_alu_res),
		.store_data_i (ex_store_data),
		.wmask_i      (ex_wmask),
		.load_ext_i   (ex_load_ext),
		.mem_op_i     (ex_mem_op),
		.reg_wen_i    (ex_reg_wen),
		.reg_waddr_i  (reg_waddr_i), // rd skips the execute stage
		.alu_res_o    (mem_alu_res),
		.store_data_o (mem_store_data),
		.wmask_o      (mem_wmask),
		.load_ext_o   (mem_load_ext),
		.mem_op_o     (mem_mem_op),
		.reg_wen_o    (mem_reg_wen),
		.reg_waddr_o  (mem_reg_waddr)
	);

	mem_stage u_mem_stage (
		.clk          (clk),
		.rst_n        (rst_n),
		.alu_res_i    (mem_alu_res),
		.store_data_i (mem_store_data),
		.wmask_i      (mem_wmask),
		.load_ext_i   (mem_load_ext),
		.mem_op_i     (mem_mem_op),
		.reg_wen_i    (mem_reg_wen),
		.reg_waddr_i  (mem_reg_waddr),
		.wb_wen_o     (wb_wen_o),
		.wb_waddr_o   (wb_waddr_o),
		.wb_data_o    (wb_data_o)
	);

endmodule

// File: verification/rv_slice_tb.sv
`timescale 1ns/1ps
`include "rv_slice_macros.svh"

module rv_slice_tb;

	logic                       clk;
	logic                       rst_n;
	logic                       flush_i;
	rv_slice_pkg::alu_op_e      alu_op_i;
	rv_slice_pkg::mem_op_e      mem_op_i;
	logic [`XLEN-1:0]           src1_i;
	logic [`XLEN-1:0]           src2_i;
	logic [31:0]                imm_i;
	logic [`REG_ADDR_WIDTH-1:0] reg_waddr_i;
	logic                       reg_wen_i;
	logic                       wb_wen_o;
	logic [`REG_ADDR_WIDTH-1:0] wb_waddr_o;
	logic [`XLEN-1:0]           wb_data_o;

	string                      lines[$];
	logic                       loaded;
	integer                     seed;

	// expected writeback, oldest op first
	logic                       exp_wen_q[$];
	logic [`REG_ADDR_WIDTH-1:0] exp_waddr_q[$];
	logic [`XLEN-1:0]           exp_data_q[$];

	rv_slice_top u_rv_slice_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.flush_i     (flush_i),
		.alu_op_i    (alu_op_i),
		.mem_op_i    (mem_op_i),
		.src1_i      (src1_i),
		.src2_i      (src2_i),
		.imm_i       (imm_i),
		.reg_waddr_i (reg_waddr_i),
		.reg_wen_i   (reg_wen_i),
		.wb_wen_o    (wb_wen_o),
		.wb_waddr_o  (wb_waddr_o),
		.wb_data_o   (wb_data_o)
	);

	always #10 clk = ~clk;

	task automatic abort_run();
		$display("STATUS: FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic check_wen(input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("Error wb_wen_o expected 0x%h got 0x%h", expected, actual);
			abort_run();
		end
	endtask

	task automatic check_waddr(input logic [`REG_ADDR_WIDTH-1:0] actual,
		input logic [`REG_ADDR_WIDTH-1:0] expected);
		if (actual !== expected) begin
			$display("Error wb_waddr_o expected 0x%h got 0x%h", expected, actual);
			abort_run();
		end
	endtask

	task automatic check_data(input logic [`XLEN-1:0] actual, input logic [`XLEN-1:0] expected);
		if (actual !== expected) begin
			$display("Error wb_data_o expected 0x%h got 0x%h", expected, actual);
			abort_run();
		end
	endtask

	// runs at a rising edge, wb_* still hold the previous cycle
	task automatic retire(input int depth);
		logic                       ewen;
		logic [`REG_ADDR_WIDTH-1:0] ewa;
		logic [`XLEN-1:0]           edata;
		if (exp_wen_q.size() >= depth) begin
			ewen  = exp_wen_q.pop_front();
			ewa   = exp_waddr_q.pop_front();
			edata = exp_data_q.pop_front();
			check_wen(wb_wen_o, ewen);
			check_waddr(wb_waddr_o, ewa);
			check_data(wb_data_o, edata);
		end else begin
			check_wen(wb_wen_o, 1'b0); // pipeline still filling
		end
	endtask

	task automatic drive_op(input logic fl, input logic [3:0] aop, input logic [3:0] mop,
		input logic [`XLEN-1:0] s1, input logic [`XLEN-1:0] s2, input logic [31:0] imm,
		input logic [`REG_ADDR_WIDTH-1:0] wa, input logic we, input logic ewen,
		input logic [`XLEN-1:0] edata);
		@(posedge clk);
		retire(3); // op driven three edges ago is on wb_* now
		flush_i     <= fl;
		alu_op_i    <= rv_slice_pkg::alu_op_e'(aop);
		mem_op_i    <= rv_slice_pkg::mem_op_e'(mop);
		src1_i      <= s1;
		src2_i      <= s2;
		imm_i       <= imm;
		reg_waddr_i <= wa;
		reg_wen_i   <= we;
		exp_wen_q.push_back(ewen);
		exp_waddr_q.push_back(wa); // rd passes straight through
		exp_data_q.push_back(edata);
	endtask

	// idle cycle, 0 + 0 with no write
	task automatic drive_idle();
		integer rnd;
		rnd = $random(seed);
		drive_op(1'b0, 4'h0, 4'h0, '0, '0, '0, rnd[`REG_ADDR_WIDTH-1:0], 1'b0, 1'b0, '0);
	endtask

	task automatic load_tests();
		integer fd;
		string  line;
		fd = $fopen("verification/rv_slice_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open the tests file verification/rv_slice_tests.txt");
			abort_run();
		end else begin
			while (!$feof(fd)) begin
				line = "";
				if ($fgets(line, fd) != 0)
					lines.push_back(line);
			end
			$fclose(fd);
		end
	endtask

	task automatic run_line(input string line);
		int                         cnt;
		logic                       fl;
		logic [3:0]                 aop;
		logic [3:0]                 mop;
		logic [`XLEN-1:0]           s1;
		logic [`XLEN-1:0]           s2;
		logic [31:0]                imm;
		logic [`REG_ADDR_WIDTH-1:0] wa;
		logic                       we;
		logic                       ewen;
		logic [`XLEN-1:0]           edata;
		if (line.len() >= 2) begin
			if (line.substr(0, 1) == "//") begin
				drive_idle();
			end else begin
				cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
					fl, aop, mop, s1, s2, imm, wa, we, ewen, edata);
				if (cnt != 10) begin
					$display("the tests file has a line that does not parse: %s", line);
					abort_run();
				end else begin
					drive_op(fl, aop, mop, s1, s2, imm, wa, we, ewen, edata);
				end
			end
		end
	endtask

	// one cycle per line plus reset and drain, with slack
	initial begin
		wait (loaded);
		#((lines.size() + 10) * 20);
		$display("watchdog expired before all tests were checked");
		abort_run();
	end

	initial begin
		clk         = 1'b0;
		rst_n       = 1'b0;
		flush_i     = 1'b0;
		alu_op_i    = rv_slice_pkg::ALU_ADD;
		mem_op_i    = rv_slice_pkg::MEM_NONE;
		src1_i      = '0;
		src2_i      = '0;
		imm_i       = '0;
		reg_waddr_i = '0;
		reg_wen_i   = 1'b0;
		seed        = 32'h1d2e9ce8;
		loaded      = 1'b0;
		load_tests();
		loaded = 1'b1;
		repeat (2) begin
			@(posedge clk);
			check_wen(wb_wen_o, 1'b0); // quiet during reset
		end
		rst_n <= 1'b1;
		foreach (lines[i])
			run_line(lines[i]);
		while (exp_wen_q.size() > 0) begin
			@(posedge clk);
			retire(1);
		end
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// File: all.f
+incdir+design
design/rv_slice_pkg.sv
design/ex_stage.sv
design/ex_mem_regs.sv
design/mem_stage.sv
design/rv_slice_top.sv
verification/rv_slice_tb.sv

// File: Makefile
TOP := rv_slice_tb

sim:
	verilator --binary --timing --timescale 1ns/1ps -f all.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: verification/rv_slice_tests.txt
// flush alu_op mem_op src1 src2 imm waddr wen, then expected wb_wen wb_data, all hex
// every comment line runs one idle cycle through the pipeline
// alu ops
0 0 0 7fffffffffffffff 0000000000000001 00000000 01 1 1 8000000000000000
0 1 0 0000000000000000 0000000000000001 00000000 02 1 1 ffffffffffffffff
0 2 0 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 00000000 03 1 1 f000f000f000f000
0 3 0 f0f0f0f0f0f0f0f0 0f0f0000000000ff 00000000 04 1 1 fffff0f0f0f0f0ff
0 4 0 123456789abcdef0 ffffffffffffffff 00000000 05 1 1 edcba9876543210f
0 5 0 00000000000000ff 0000000000000044 00000000 06 1 1 0000000000000ff0
0 6 0 8000000000000000 000000000000003f 00000000 07 1 1 0000000000000001
0 7 0 8000000000000000 0000000000000004 00000000 08 1 1 f800000000000000
0 8 0 ffffffffffffffff 0000000000000001 00000000 09 1 1 0000000000000001
0 9 0 ffffffffffffffff 0000000000000001 00000000 0a 1 1 0000000000000000
0 0 0 0000000000000002 0000000000000003 00000000 0b 0 0 0000000000000005
// stores of each size, each followed at once by a doubleword load
0 0 b 0000000000000100 1122334455667788 00000000 0c 1 0 0000000000000100
0 0 4 0000000000000100 0000000000000000 00000000 0d 1 1 1122334455667788
0 0 8 0000000000000100 00000000000000aa 00000003 0e 1 0 0000000000000103
0 0 4 0000000000000100 0000000000000000 00000000 0f 1 1 11223344aa667788
0 0 9 0000000000000100 000000000000bbcc 00000006 10 1 0 0000000000000106
0 0 4 0000000000000100 0000000000000000 00000000 11 1 1 bbcc3344aa667788
0 0 a 0000000000000100 00000000deadbeef 00000004 12 1 0 0000000000000104
0 0 4 0000000000000100 0000000000000000 00000000 13 1 1 deadbeefaa667788
0 0 9 0000000000000100 0000000000008001 00000002 14 1 0 0000000000000102
0 0 4 0000000000000100 0000000000000000 00000000 15 1 1 deadbeef80017788
// load widths, sign and lane on the word at 0x100
0 0 1 0000000000000100 0000000000000000 00000000 16 1 1 ffffffffffffff88
0 0 5 0000000000000100 0000000000000000 00000000 17 1 1 0000000000000088
0 0 1 0000000000000100 0000000000000000 00000001 18 1 1 0000000000000077
0 0 2 0000000000000100 0000000000000000 00000002 19 1 1 ffffffffffff8001
0 0 6 0000000000000100 0000000000000000 00000002 1a 1 1 0000000000008001
0 0 3 0000000000000100 0000000000000000 00000004 1b 1 1 ffffffffdeadbeef
0 0 7 0000000000000100 0000000000000000 00000004 1c 1 1 00000000deadbeef
0 0 3 0000000000000100 0000000000000000 00000000 1d 1 1 ffffffff80017788
0 0 4 0000000000000108 0000000000000000 fffffff8 1e 1 1 deadbeef80017788
// flushed ops write nothing
1 0 b 0000000000000100 0000000000000000 00000000 1f 1 0 0000000000000100
0 0 4 0000000000000100 0000000000000000 00000000 01 1 1 deadbeef80017788
1 0 0 0000000000000001 0000000000000001 00000000 02 1 0 0000000000000002
// top word, then read back one memory size higher
0 0 b 00000000000001f8 0102030405060708 00000000 03 1 0 00000000000001f8
0 0 4 00000000000003f8 0000000000000000 00000000 04 1 1 0102030405060708
